/* logic/axi_line_defines.svh */
`ifndef AXI_LINE_DEFINES_SVH
`define AXI_LINE_DEFINES_SVH

// line geometry
`define LINE_WORDS 16
`define WORD_W     32
`define ADDR_W     32

// read burst ids
`define ID_W       4
`define ICACHE_ID  0
`define DCACHE_ID  1

`endif

/* logic/axi_line_pkg.sv */
`include "axi_line_defines.svh"

package axi_line_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // beat k sits at bits 32k up to 32k+31
    typedef logic [`LINE_WORDS*`WORD_W-1:0] line_t;

    typedef logic [`ID_W-1:0] axi_id_t;
    typedef logic [$clog2(`LINE_WORDS)-1:0] beat_idx_t;

endpackage

/* logic/rd_bus_if.sv */
`timescale 1ns/1ps

interface rd_bus_if
    import axi_line_pkg::*;
();

    logic  ar_valid;
    addr_t ar_addr;
    logic  ar_ready;
    logic  r_valid;
    word_t r_data;
    logic  r_last;

    modport requester (
        output ar_valid,
        output ar_addr,
        input  ar_ready,
        input  r_valid,
        input  r_data,
        input  r_last
    );

    modport arbiter (
        input  ar_valid,
        input  ar_addr,
        output ar_ready,
        output r_valid,
        output r_data,
        output r_last
    );

endinterface

/* logic/line_refill.sv */
`timescale 1ns/1ps
`include "axi_line_defines.svh"

module line_refill
    import axi_line_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  addr_t       addr,
    rd_bus_if.requester rd,
    output line_t       line,
    output logic        refresh
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_t;

    state_t    state;
    addr_t     addr_q;
    beat_idx_t beat;
    line_t     line_buf;
    line_t     assembled;

    assign rd.ar_valid = (state == ADDR);  // held until ar_ready
    assign rd.ar_addr  = addr_q;

    always_comb begin
        assembled = line_buf;
        assembled[beat * `WORD_W +: `WORD_W] = rd.r_data;  // beat into its slot
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            beat    <= '0;
            refresh <= 1'b0;
        end else begin
            refresh <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin  // start while busy is dropped
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    beat <= '0;
                    if (rd.ar_ready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (rd.r_valid) begin
                        beat <= beat + 1'b1;
                        if (rd.r_last) begin
                            state   <= IDLE;
                            refresh <= 1'b1;  // one cycle after rlast beat
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            addr_q <= addr;
        end
        if (state == DATA && rd.r_valid) begin
            line_buf <= assembled;
            if (rd.r_last) begin
                line <= assembled;  // stable until next refresh
            end
        end
    end

endmodule

/* logic/line_writeback.sv */
`timescale 1ns/1ps
`include "axi_line_defines.svh"

module line_writeback
    import axi_line_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  addr_t addr,
    input  line_t line,
    output addr_t awaddr,
    output logic  awvalid,
    input  logic  awready,
    output word_t wdata,
    output logic  wlast,
    output logic  wvalid,
    input  logic  wready,
    input  logic  bvalid,
    output logic  bready,
    output logic  done
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } state_t;

    state_t    state;
    addr_t     addr_q;
    line_t     line_q;
    beat_idx_t beat;

    assign awaddr  = addr_q;
    assign awvalid = (state == ADDR);
    assign wvalid  = (state == DATA);
    assign wdata   = line_q[beat * `WORD_W +: `WORD_W];
    assign wlast   = wvalid && (beat == beat_idx_t'(`LINE_WORDS - 1));
    assign bready  = (state != IDLE);  // from aw issue until bvalid

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            beat  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    beat <= '0;
                    if (awready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (wlast) begin
                            state <= RESP;
                        end
                    end
                end
                RESP: begin
                    if (bvalid) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // old line captured with the request pulse
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            addr_q <= addr;
            line_q <= line;
        end
    end

endmodule

/* logic/dcache_miss_unit.sv */
`timescale 1ns/1ps

module dcache_miss_unit
    import axi_line_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        dcache_re,
    input  addr_t       dcache_raddr,
    input  logic        dcache_we,
    input  addr_t       dcache_waddr,
    input  line_t       dcache_cacheline_old,
    output line_t       dcache_cacheline_new,
    output logic        dcache_refresh,
    output addr_t       awaddr,
    output logic        awvalid,
    input  logic        awready,
    output word_t       wdata,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    rd_bus_if.requester rd
);

    logic  refill_pending;
    addr_t raddr_q;
    logic  wb_done;
    logic  refill_start;
    addr_t refill_addr;

    // refill waits for the write-back so it never reads stale memory
    assign refill_start = (dcache_re && !dcache_we) || (wb_done && refill_pending);
    assign refill_addr  = wb_done ? raddr_q : dcache_raddr;

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_pending <= 1'b0;
        end else if (dcache_re && dcache_we) begin
            refill_pending <= 1'b1;
        end else if (wb_done) begin
            refill_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dcache_re && dcache_we) begin
            raddr_q <= dcache_raddr;
        end
    end

    line_writeback dcache_wb_i (
        .clk     (clk),
        .reset   (reset),
        .start   (dcache_we),
        .addr    (dcache_waddr),
        .line    (dcache_cacheline_old),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .done    (wb_done)
    );

    line_refill dcache_refill_i (
        .clk     (clk),
        .reset   (reset),
        .start   (refill_start),
        .addr    (refill_addr),
        .rd      (rd),
        .line    (dcache_cacheline_new),
        .refresh (dcache_refresh)
    );

endmodule

/* logic/read_arbiter.sv */
`timescale 1ns/1ps
`include "axi_line_defines.svh"

module read_arbiter
    import axi_line_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    rd_bus_if.arbiter icache_rd,
    rd_bus_if.arbiter dcache_rd,
    output axi_id_t   arid,
    output addr_t     araddr,
    output logic      arvalid,
    input  logic      arready,
    input  word_t     rdata,
    input  logic      rlast,
    input  logic      rvalid,
    output logic      rready
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_t;

    state_t state;
    logic   owner;  // 1 means dcache port
    logic   grant;

    // on a tie the port that did not own the last burst wins
    always_comb begin
        if (icache_rd.ar_valid && dcache_rd.ar_valid) begin
            grant = ~owner;
        end else begin
            grant = dcache_rd.ar_valid;
        end
    end

    assign arvalid = (state == ADDR);
    assign araddr  = owner ? dcache_rd.ar_addr : icache_rd.ar_addr;
    assign arid    = owner ? axi_id_t'(`DCACHE_ID) : axi_id_t'(`ICACHE_ID);
    assign rready  = (state == DATA);  // owner always takes beats

    assign icache_rd.ar_ready = arvalid && !owner && arready;
    assign dcache_rd.ar_ready = arvalid && owner && arready;
    assign icache_rd.r_valid  = rready && !owner && rvalid;
    assign dcache_rd.r_valid  = rready && owner && rvalid;
    assign icache_rd.r_data   = rdata;
    assign dcache_rd.r_data   = rdata;
    assign icache_rd.r_last   = rlast;
    assign dcache_rd.r_last   = rlast;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            owner <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (icache_rd.ar_valid || dcache_rd.ar_valid) begin
                        owner <= grant;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (arready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (rvalid && rlast) begin  // ownership released here
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/axi_line_ctrl.sv */
`timescale 1ns/1ps

module axi_line_ctrl
    import axi_line_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    // icache side
    input  logic    icache_re,
    input  addr_t   icache_raddr,
    output line_t   icache_cacheline_new,
    output logic    icache_refresh,

    // dcache side
    input  logic    dcache_re,
    input  addr_t   dcache_raddr,
    input  logic    dcache_we,
    input  addr_t   dcache_waddr,
    input  line_t   dcache_cacheline_old,
    output line_t   dcache_cacheline_new,
    output logic    dcache_refresh,

    // read channels
    output axi_id_t arid,
    output addr_t   araddr,
    output logic    arvalid,
    input  logic    arready,
    input  word_t   rdata,
    input  logic    rlast,
    input  logic    rvalid,
    output logic    rready,

    // write channels
    output addr_t   awaddr,
    output logic    awvalid,
    input  logic    awready,
    output word_t   wdata,
    output logic    wlast,
    output logic    wvalid,
    input  logic    wready,
    input  logic    bvalid,
    output logic    bready
);

    rd_bus_if icache_rd ();
    rd_bus_if dcache_rd ();

    line_refill icache_refill_i (
        .clk     (clk),
        .reset   (reset),
        .start   (icache_re),
        .addr    (icache_raddr),
        .rd      (icache_rd),
        .line    (icache_cacheline_new),
        .refresh (icache_refresh)
    );

    dcache_miss_unit dcache_miss_i (
        .clk                  (clk),
        .reset                (reset),
        .dcache_re            (dcache_re),
        .dcache_raddr         (dcache_raddr),
        .dcache_we            (dcache_we),
        .dcache_waddr         (dcache_waddr),
        .dcache_cacheline_old (dcache_cacheline_old),
        .dcache_cacheline_new (dcache_cacheline_new),
        .dcache_refresh       (dcache_refresh),
        .awaddr               (awaddr),
        .awvalid              (awvalid),
        .awready              (awready),
        .wdata                (wdata),
        .wlast                (wlast),
        .wvalid               (wvalid),
        .wready               (wready),
        .bvalid               (bvalid),
        .bready               (bready),
        .rd                   (dcache_rd)
    );

    read_arbiter read_arb_i (
        .clk       (clk),
        .reset     (reset),
        .icache_rd (icache_rd),
        .dcache_rd (dcache_rd),
        .arid      (arid),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

/* dv/axi_slave_model.sv */
`timescale 1ns/1ps
`include "axi_line_defines.svh"

module axi_slave_model
    import axi_line_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall_en,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output logic  rlast,
    output logic  rvalid,
    input  logic  rready,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata,
    input  logic  wlast,
    input  logic  wvalid,
    output logic  wready,
    output logic  bvalid,
    input  logic  bready
);

    word_t       mem [addr_t];
    logic [31:0] rnd;
    logic        reset_q;
    logic        rd_busy, wr_busy, resp_pending;
    addr_t       rd_addr, wr_addr;
    int          rd_beat, wr_beat;

    function automatic logic [31:0] lcg_next(logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // ready about three cycles in four with stalls on
    function automatic logic not_stalled();
        rnd = lcg_next(rnd);
        return !stall_en || (rnd[31:30] != 2'b00);
    endfunction

    function automatic word_t read_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return lcg_next(a);  // unwritten memory fill
    endfunction

    initial begin
        rnd = 32'h3d2a_37c7;
        reset_q = 1'b1;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        resp_pending = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        rd_beat = 0;
        wr_beat = 0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        forever begin
            @(posedge clk);
            reset_q = reset;
            if (reset) begin
                rd_busy = 1'b0;
                wr_busy = 1'b0;
                resp_pending = 1'b0;
            end else begin
                if (arvalid && arready) begin
                    rd_busy = 1'b1;
                    rd_addr = araddr;
                    rd_beat = 0;
                end else if (rvalid && rready) begin
                    if (rlast) begin
                        rd_busy = 1'b0;
                    end else begin
                        rd_beat++;
                    end
                end
                if (awvalid && awready) begin
                    wr_busy = 1'b1;
                    wr_addr = awaddr;
                    wr_beat = 0;
                end else if (wvalid && wready) begin
                    mem[wr_addr + addr_t'(4 * wr_beat)] = wdata;
                    wr_beat++;
                    if (wlast) begin
                        wr_busy = 1'b0;
                        resp_pending = 1'b1;
                    end
                end else if (bvalid && bready) begin
                    resp_pending = 1'b0;
                end
            end
            #1;
            arready = !reset_q && !rd_busy && not_stalled();
            rvalid  = !reset_q && rd_busy && not_stalled();
            rdata   = rvalid ? read_word(rd_addr + addr_t'(4 * rd_beat)) : '0;
            rlast   = rvalid && (rd_beat == `LINE_WORDS - 1);
            awready = !reset_q && !wr_busy && !resp_pending && not_stalled();
            wready  = !reset_q && wr_busy && not_stalled();
            bvalid  = !reset_q && resp_pending && not_stalled();
        end
    end

endmodule

/* dv/axi_line_tb.sv */
`timescale 1ns/1ps
`include "axi_line_defines.svh"

module axi_line_tb
    import axi_line_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int MAX_OPS       = 40;
    localparam int CYCLES_PER_OP = 400;

    logic    clk, reset, stall_en;
    logic    icache_re, icache_refresh, dcache_re, dcache_we, dcache_refresh;
    addr_t   icache_raddr, dcache_raddr, dcache_waddr, araddr, awaddr;
    line_t   icache_cacheline_new, dcache_cacheline_old, dcache_cacheline_new;
    axi_id_t arid;
    logic    arvalid, arready, rlast, rvalid, rready;
    logic    awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    word_t   rdata, wdata;

    word_t       ref_mem [addr_t];  // every write beat seen on the bus
    logic [31:0] rnd;
    int          checks, mismatches, failures, wr_beat;
    logic        ic_busy, ic_wait_ar, dc_busy, dc_wait_ar, dc_refill, wb_open, rd_open;
    addr_t       ic_addr, dc_addr, wb_addr;
    line_t       wb_line;

    axi_line_ctrl axi_line_ctrl_i (.*);
    axi_slave_model slave_i (.*);

    function automatic logic [31:0] lcg_next(logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t mem_word(addr_t a);
        return lcg_next(a);
    endfunction

    function automatic line_t expected_line(addr_t a);
        line_t l;
        addr_t wa;
        for (int k = 0; k < `LINE_WORDS; k++) begin
            wa = a + addr_t'(4 * k);
            l[k*`WORD_W +: `WORD_W] = ref_mem.exists(wa) ? ref_mem[wa] : mem_word(wa);
        end
        return l;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd = lcg_next(rnd);
        return rnd;
    endfunction

    function automatic addr_t rand_line_addr();
        logic [31:0] r;
        r = next_rand();
        return {r[31:6], 6'b0};  // 64-byte line aligned
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < `LINE_WORDS; k++) begin
            l[k*`WORD_W +: `WORD_W] = next_rand();
        end
        return l;
    endfunction

    task automatic check_line(string name, line_t got, line_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_id(string name, axi_id_t got, axi_id_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // control outputs that must sit low while reset holds
    task automatic check_idle_outputs();
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("rready", rready, 1'b0);
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("wlast", wlast, 1'b0);
        check_flag("bready", bready, 1'b0);
        check_flag("icache_refresh", icache_refresh, 1'b0);
        check_flag("dcache_refresh", dcache_refresh, 1'b0);
    endtask

    task automatic report_failure(string what);
        failures++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // drives one set of cache pulses and waits until every port is idle again
    task automatic run_requests(logic ic_re, addr_t ic_a, logic dc_re, addr_t dc_ra,
                                logic dc_we, addr_t dc_wa, line_t old);
        @(posedge clk);
        #1;
        icache_re = ic_re;
        icache_raddr = ic_a;
        dcache_re = dc_re;
        dcache_raddr = dc_ra;
        dcache_we = dc_we;
        dcache_waddr = dc_wa;
        dcache_cacheline_old = old;
        ic_busy = ic_re;
        ic_wait_ar = ic_re;
        ic_addr = ic_a;
        dc_busy = dc_re || dc_we;
        dc_wait_ar = dc_re;
        dc_refill = dc_re;
        dc_addr = dc_ra;
        wb_open = dc_we;
        wb_addr = dc_wa;
        wb_line = old;
        @(posedge clk);
        #1;
        icache_re = 1'b0;
        dcache_re = 1'b0;
        dcache_we = 1'b0;
        while (ic_busy || dc_busy) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bus monitor and compare process
    always @(posedge clk) begin
        if (!reset) begin
            if (arvalid && arready) begin
                if (rd_open) begin
                    report_failure("second read burst accepted before rlast of the first");
                end
                rd_open = 1'b1;
                if (ic_wait_ar && (!dc_wait_ar || arid == axi_id_t'(`ICACHE_ID))) begin
                    check_id("arid", arid, axi_id_t'(`ICACHE_ID));
                    check_addr("araddr", araddr, ic_addr);
                    ic_wait_ar = 1'b0;
                end else if (dc_wait_ar) begin
                    if (wb_open) begin
                        report_failure("dcache refill started before its write-back finished");
                    end
                    check_id("arid", arid, axi_id_t'(`DCACHE_ID));
                    check_addr("araddr", araddr, dc_addr);
                    dc_wait_ar = 1'b0;
                end else begin
                    report_failure("read burst issued with no cache request pending");
                end
            end
            if (rvalid && rready && rlast) begin
                rd_open = 1'b0;  // ownership passes here
            end
            if (awvalid && awready) begin
                check_addr("awaddr", awaddr, wb_addr);
                wr_beat = 0;
            end
            if (wvalid && wready) begin
                check_word("wdata", wdata, wb_line[wr_beat*`WORD_W +: `WORD_W]);
                check_flag("wlast", wlast, wr_beat == `LINE_WORDS - 1);
                ref_mem[wb_addr + addr_t'(4 * wr_beat)] = wb_line[wr_beat*`WORD_W +: `WORD_W];
                wr_beat++;
            end
            if (bvalid && bready) begin
                wb_open = 1'b0;
                if (!dc_refill) begin
                    dc_busy = 1'b0;  // write-back only request ends here
                end
            end
            if (icache_refresh) begin
                if (ic_wait_ar) begin
                    report_failure("icache refresh without its read burst");
                end
                check_line("icache_cacheline_new", icache_cacheline_new, expected_line(ic_addr));
                ic_busy = 1'b0;
            end
            if (dcache_refresh) begin
                if (dc_wait_ar) begin
                    report_failure("dcache refresh without its read burst");
                end
                check_line("dcache_cacheline_new", dcache_cacheline_new, expected_line(dc_addr));
                dc_busy = 1'b0;
            end
        end
    end

    initial begin
        addr_t a;
        addr_t b;
        line_t old;
        reset = 1'b1;
        stall_en = 1'b0;
        icache_re = 1'b0;
        icache_raddr = '0;
        dcache_re = 1'b0;
        dcache_raddr = '0;
        dcache_we = 1'b0;
        dcache_waddr = '0;
        dcache_cacheline_old = '0;
        rnd = 32'h3d2a_37c7;
        checks = 0;
        mismatches = 0;
        failures = 0;
        wr_beat = 0;
        {ic_busy, ic_wait_ar, dc_busy, dc_wait_ar, dc_refill, wb_open, rd_open} = '0;
        {ic_addr, dc_addr, wb_addr} = '0;
        wb_line = '0;
        repeat (5) @(posedge clk);
        #1;
        check_idle_outputs();
        reset = 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);  // second pass stalls every channel
            a = rand_line_addr();
            run_requests(1'b1, a, 1'b0, '0, 1'b0, '0, '0);
            run_requests(1'b0, '0, 1'b1, a ^ 32'h40, 1'b0, '0, '0);
            b = rand_line_addr();
            old = rand_line();
            run_requests(1'b0, '0, 1'b0, '0, 1'b1, b, old);
            run_requests(1'b0, '0, 1'b1, b, 1'b0, '0, '0);  // read back written line
            run_requests(1'b1, b, 1'b0, '0, 1'b0, '0, '0);
            old = rand_line();
            run_requests(1'b0, '0, 1'b1, b, 1'b1, b, old);  // same line, write first
            old = rand_line();
            run_requests(1'b0, '0, 1'b1, b ^ 32'h4000, 1'b1, b, old);
            a = rand_line_addr();
            run_requests(1'b1, a, 1'b1, a ^ 32'h1000, 1'b0, '0, '0);
            old = rand_line();
            run_requests(1'b1, a, 1'b1, a ^ 32'h2000, 1'b1, a ^ 32'h2000, old);
        end
        repeat (5) @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && checks > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(MAX_OPS * CYCLES_PER_OP * CLK_PERIOD);
        report_failure("run did not finish in time, a request never completed");
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/axi_line_pkg.sv
logic/rd_bus_if.sv
logic/line_refill.sv
logic/line_writeback.sv
logic/dcache_miss_unit.sv
logic/read_arbiter.sv
logic/axi_line_ctrl.sv
dv/axi_slave_model.sv
dv/axi_line_tb.sv
